// File: include/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// address split, 16-bit byte address
`define DC_ADDR_W      16
`define DC_TAG_W       6
`define DC_INDEX_W     6
`define DC_OFFSET_W    4

// one cache line is one cpu word
`define DC_LINE_W      128
`define DC_LINES       64

// memory model, 2**(tag + index) lines
`define DC_MEM_LINES   4096
`define DC_MEM_LAT     4

`endif

// File: design/dcache_pkg.sv
`include "dcache_cfg.svh"

package dcache_pkg;

  //////////////////////////////
  // address views
  //////////////////////////////

  // cache side: tag / index / byte offset
  typedef struct packed {
    logic [`DC_TAG_W-1:0]    tag;
    logic [`DC_INDEX_W-1:0]  index;
    logic [`DC_OFFSET_W-1:0] offset;
  } cache_addr_t;

  // memory side: line address / byte offset
  typedef struct packed {
    logic [`DC_ADDR_W-`DC_OFFSET_W-1:0] line_addr;
    logic [`DC_OFFSET_W-1:0]            offset;
  } mem_addr_t;

  typedef union packed {
    cache_addr_t cache;
    mem_addr_t   mem;
  } addr_u;

  //////////////////////////////
  // channel words
  //////////////////////////////

  typedef struct packed {
    logic                  write;
    addr_u                 addr;
    logic [`DC_LINE_W-1:0] wdata;
  } cpu_req_t;

  // rdata holds the written line on a write
  typedef struct packed {
    logic                  write;
    logic [`DC_LINE_W-1:0] rdata;
  } cpu_rsp_t;

  typedef struct packed {
    logic                              write;
    logic [`DC_TAG_W+`DC_INDEX_W-1:0]  line_addr;
    logic [`DC_LINE_W-1:0]             wdata;
  } mem_cmd_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WRITEBACK,
    ST_REFILL,
    ST_UPDATE,
    ST_RESPOND
  } ctrl_state_e;

endpackage

// File: design/tag_store.sv
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module tag_store (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`DC_INDEX_W-1:0] index,
  input  logic [`DC_TAG_W-1:0]   tag_in,
  input  logic                   lookup,
  input  logic                   write,
  input  logic                   dirty_set,
  output logic                   hit,
  output logic                   dirty,
  output logic [`DC_TAG_W-1:0]   victim_tag
);

  logic [`DC_TAG_W-1:0] tag_q [`DC_LINES];
  logic [`DC_LINES-1:0] valid_q;
  logic [`DC_LINES-1:0] dirty_q;

  //////////////////////////////
  // storage
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (write) tag_q[index] <= tag_in;
  end

  // valid and dirty flags start clear
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (write) begin
      valid_q[index] <= 1'b1;
      dirty_q[index] <= dirty_set;
    end
  end

  //////////////////////////////
  // registered lookup
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hit   <= 1'b0;
      dirty <= 1'b0;
    end else if (lookup) begin
      hit   <= valid_q[index] && (tag_q[index] == tag_in);
      // an invalid line never needs writeback
      dirty <= valid_q[index] && dirty_q[index];
    end
  end

  always_ff @(posedge clk) begin
    if (lookup) victim_tag <= tag_q[index];
  end

endmodule

// File: design/line_store.sv
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module line_store (
  input  logic                   clk,
  input  logic [`DC_INDEX_W-1:0] index,
  input  logic                   read,
  input  logic                   write,
  input  logic                   fill_sel,
  input  logic [`DC_LINE_W-1:0]  fill_data,
  input  logic [`DC_LINE_W-1:0]  cpu_data,
  output logic [`DC_LINE_W-1:0]  rdata
);

  logic [`DC_LINE_W-1:0] line_q [`DC_LINES];
  logic [`DC_LINE_W-1:0] wdata;

  // refill data or cpu data
  assign wdata = fill_sel ? fill_data : cpu_data;

  always_ff @(posedge clk) begin
    if (write) line_q[index] <= wdata;
  end

  // registered read, output holds until the next read
  always_ff @(posedge clk) begin
    if (read) rdata <= line_q[index];
  end

endmodule

// File: design/backing_mem.sv
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module backing_mem (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  dcache_pkg::mem_cmd_t  cmd,
  output logic                  done,
  output logic [`DC_LINE_W-1:0] rdata
);

  localparam int LINE_AW = `DC_TAG_W + `DC_INDEX_W;
  localparam int CNT_W   = $clog2(`DC_MEM_LAT + 1);
  localparam int REP     = (`DC_LINE_W + LINE_AW - 1) / LINE_AW;

  logic [`DC_LINE_W-1:0] mem [`DC_MEM_LINES];
  dcache_pkg::mem_cmd_t  cmd_q;
  logic                  busy;
  logic [CNT_W-1:0]      cnt;
  logic                  cmd_fire;

  //////////////////////////////
  // initial contents
  //////////////////////////////

  // each line holds its own line address, repeated and cut to line width
  initial begin : init_fill
    logic [REP*LINE_AW-1:0] pat;
    for (int i = 0; i < `DC_MEM_LINES; i++) begin
      pat    = {REP{LINE_AW'(i)}};
      mem[i] = pat[`DC_LINE_W-1:0];
    end
  end

  //////////////////////////////
  // latency counter
  //////////////////////////////

  assign cmd_ready = !busy;
  assign cmd_fire  = cmd_valid && cmd_ready;
  assign done      = busy && (cnt == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (cmd_fire) begin
      busy <= 1'b1;
      cnt  <= CNT_W'(`DC_MEM_LAT - 1);
    end else if (done) begin
      busy <= 1'b0;
    end else if (busy) begin
      cnt <= cnt - 1'b1;
    end
  end

  // command capture, read data taken at accept
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      cmd_q <= cmd;
      if (!cmd.write) rdata <= mem[cmd.line_addr];
    end
  end

  // write lands on the done edge
  always @(posedge clk) begin
    if (done && cmd_q.write) mem[cmd_q.line_addr] <= cmd_q.wdata;
  end

endmodule

// File: design/dcache_ctrl.sv
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module dcache_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  // cpu side
  input  logic                   req_valid,
  output logic                   req_ready,
  input  dcache_pkg::cpu_req_t   req,
  output logic                   rsp_valid,
  input  logic                   rsp_ready,
  output dcache_pkg::cpu_rsp_t   rsp,
  // tag store
  output logic [`DC_INDEX_W-1:0] tag_index,
  output logic [`DC_TAG_W-1:0]   tag_in,
  output logic                   tag_lookup,
  output logic                   tag_write,
  output logic                   tag_dirty_set,
  input  logic                   hit,
  input  logic                   dirty,
  input  logic [`DC_TAG_W-1:0]   victim_tag,
  // line store
  output logic [`DC_INDEX_W-1:0] line_index,
  output logic                   line_read,
  output logic                   line_write,
  output logic                   line_fill_sel,
  output logic [`DC_LINE_W-1:0]  line_wdata,
  input  logic [`DC_LINE_W-1:0]  line_rdata,
  // memory model
  output logic                   mem_cmd_valid,
  input  logic                   mem_cmd_ready,
  output dcache_pkg::mem_cmd_t   mem_cmd,
  input  logic                   mem_done,
  input  logic [`DC_LINE_W-1:0]  mem_rdata
);

  dcache_pkg::ctrl_state_e state;
  dcache_pkg::ctrl_state_e next_state;
  dcache_pkg::cpu_req_t    req_q;
  dcache_pkg::cpu_rsp_t    rsp_q;
  dcache_pkg::addr_u       cur_addr;
  dcache_pkg::addr_u       victim_addr;
  logic [`DC_LINE_W-1:0]   fill_q;
  logic                    filled;
  logic                    cmd_sent;
  logic                    req_fire;
  logic                    in_wb;

  assign req_ready = (state == dcache_pkg::ST_IDLE);
  assign req_fire  = req_valid && req_ready;
  assign rsp_valid = (state == dcache_pkg::ST_RESPOND);
  assign rsp       = rsp_q;
  assign in_wb     = (state == dcache_pkg::ST_WRITEBACK);

  // lookup is issued on the accept edge, so use the incoming address while idle
  assign cur_addr   = req_ready ? req.addr : req_q.addr;
  assign tag_index  = cur_addr.cache.index;
  assign tag_in     = cur_addr.cache.tag;
  assign tag_lookup = req_fire;
  assign line_index = cur_addr.cache.index;
  assign line_read  = req_fire;
  assign line_wdata = req_q.wdata;

  //////////////////////////////
  // memory command
  //////////////////////////////

  // victim line address, rebuilt from the stored tag
  always_comb begin
    victim_addr           = req_q.addr;
    victim_addr.cache.tag = victim_tag;
  end

  assign mem_cmd_valid = (in_wb || state == dcache_pkg::ST_REFILL) && !cmd_sent;

  always_comb begin
    mem_cmd.write     = in_wb;
    mem_cmd.line_addr = in_wb ? victim_addr.mem.line_addr : req_q.addr.mem.line_addr;
    // victim data still sits on the line store output from the lookup
    mem_cmd.wdata     = line_rdata;
  end

  //////////////////////////////
  // fsm
  //////////////////////////////

  always_comb begin
    next_state    = state;
    tag_write     = 1'b0;
    tag_dirty_set = 1'b0;
    line_write    = 1'b0;
    line_fill_sel = 1'b0;
    case (state)
      dcache_pkg::ST_IDLE: begin
        if (req_fire) next_state = dcache_pkg::ST_LOOKUP;
      end
      dcache_pkg::ST_LOOKUP: begin
        if (hit) next_state = dcache_pkg::ST_UPDATE;
        else if (dirty) next_state = dcache_pkg::ST_WRITEBACK;
        else next_state = dcache_pkg::ST_REFILL;
      end
      dcache_pkg::ST_WRITEBACK: begin
        if (mem_done) next_state = dcache_pkg::ST_REFILL;
      end
      dcache_pkg::ST_REFILL: begin
        // install the fetched line clean
        if (mem_done) begin
          next_state    = dcache_pkg::ST_UPDATE;
          tag_write     = 1'b1;
          line_write    = 1'b1;
          line_fill_sel = 1'b1;
        end
      end
      dcache_pkg::ST_UPDATE: begin
        tag_write     = req_q.write;
        tag_dirty_set = req_q.write;
        line_write    = req_q.write;
        next_state    = dcache_pkg::ST_RESPOND;
      end
      dcache_pkg::ST_RESPOND: begin
        if (rsp_ready) next_state = dcache_pkg::ST_IDLE;
      end
      default: next_state = dcache_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= dcache_pkg::ST_IDLE;
      cmd_sent <= 1'b0;
      filled   <= 1'b0;
    end else begin
      state <= next_state;
      if (mem_done) cmd_sent <= 1'b0;
      else if (mem_cmd_valid && mem_cmd_ready) cmd_sent <= 1'b1;
      if (req_fire) filled <= 1'b0;
      else if (state == dcache_pkg::ST_REFILL && mem_done) filled <= 1'b1;
    end
  end

  // request, refill and response registers
  always_ff @(posedge clk) begin
    if (req_fire) req_q <= req;
    if (state == dcache_pkg::ST_REFILL && mem_done) fill_q <= mem_rdata;
    if (state == dcache_pkg::ST_UPDATE) begin
      rsp_q.write <= req_q.write;
      if (req_q.write) rsp_q.rdata <= req_q.wdata;
      else if (filled) rsp_q.rdata <= fill_q;
      else rsp_q.rdata <= line_rdata;
    end
  end

endmodule

// File: design/data_cache.sv
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module data_cache (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_valid,
  output logic                 req_ready,
  input  dcache_pkg::cpu_req_t req,
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output dcache_pkg::cpu_rsp_t rsp
);

  // tag store
  logic [`DC_INDEX_W-1:0] tag_index;
  logic [`DC_TAG_W-1:0]   tag_in;
  logic                   tag_lookup;
  logic                   tag_write;
  logic                   tag_dirty_set;
  logic                   tag_hit;
  logic                   tag_dirty;
  logic [`DC_TAG_W-1:0]   victim_tag;

  // line store
  logic [`DC_INDEX_W-1:0] line_index;
  logic                   line_read;
  logic                   line_write;
  logic                   line_fill_sel;
  logic [`DC_LINE_W-1:0]  line_wdata;
  logic [`DC_LINE_W-1:0]  line_rdata;

  // memory model
  logic                   mem_cmd_valid;
  logic                   mem_cmd_ready;
  dcache_pkg::mem_cmd_t   mem_cmd;
  logic                   mem_done;
  logic [`DC_LINE_W-1:0]  mem_rdata;

  //////////////////////////////
  // controller
  //////////////////////////////

  dcache_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp           (rsp),
    .tag_index     (tag_index),
    .tag_in        (tag_in),
    .tag_lookup    (tag_lookup),
    .tag_write     (tag_write),
    .tag_dirty_set (tag_dirty_set),
    .hit           (tag_hit),
    .dirty         (tag_dirty),
    .victim_tag    (victim_tag),
    .line_index    (line_index),
    .line_read     (line_read),
    .line_write    (line_write),
    .line_fill_sel (line_fill_sel),
    .line_wdata    (line_wdata),
    .line_rdata    (line_rdata),
    .mem_cmd_valid (mem_cmd_valid),
    .mem_cmd_ready (mem_cmd_ready),
    .mem_cmd       (mem_cmd),
    .mem_done      (mem_done),
    .mem_rdata     (mem_rdata)
  );

  //////////////////////////////
  // storage and memory
  //////////////////////////////

  tag_store u_tags (
    .clk        (clk),
    .rst_n      (rst_n),
    .index      (tag_index),
    .tag_in     (tag_in),
    .lookup     (tag_lookup),
    .write      (tag_write),
    .dirty_set  (tag_dirty_set),
    .hit        (tag_hit),
    .dirty      (tag_dirty),
    .victim_tag (victim_tag)
  );

  // refill data comes straight from the memory model
  line_store u_lines (
    .clk       (clk),
    .index     (line_index),
    .read      (line_read),
    .write     (line_write),
    .fill_sel  (line_fill_sel),
    .fill_data (mem_rdata),
    .cpu_data  (line_wdata),
    .rdata     (line_rdata)
  );

  backing_mem u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (mem_cmd_valid),
    .cmd_ready (mem_cmd_ready),
    .cmd       (mem_cmd),
    .done      (mem_done),
    .rdata     (mem_rdata)
  );

endmodule

// File: testbench/data_cache_tb.sv
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module data_cache_tb;

  localparam int LINE_AW = `DC_TAG_W + `DC_INDEX_W;

  logic                 clk;
  logic                 rst_n;
  logic                 req_valid;
  logic                 req_ready;
  dcache_pkg::cpu_req_t req;
  logic                 rsp_valid;
  logic                 rsp_ready;
  dcache_pkg::cpu_rsp_t rsp;

  integer                seed = 32'he633;
  int                    cycle_cnt = 0;
  int                    accepted_at;
  int                    seen_at;
  dcache_pkg::cpu_rsp_t  last_rsp;
  // reference memory, keyed by line address
  logic [`DC_LINE_W-1:0] model_mem [int];

  data_cache dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  //////////////////////////////
  // reference model
  //////////////////////////////

  // line address repeated upward from bit 0
  function automatic logic [`DC_LINE_W-1:0] line_pattern(input logic [LINE_AW-1:0] line);
    logic [`DC_LINE_W-1:0] pat;
    for (int b = 0; b < `DC_LINE_W; b++) begin
      pat[b] = line[b % LINE_AW];
    end
    return pat;
  endfunction

  function automatic logic [`DC_LINE_W-1:0] model_read(input logic [LINE_AW-1:0] line);
    if (model_mem.exists(int'(line))) return model_mem[int'(line)];
    return line_pattern(line);
  endfunction

  function automatic logic [`DC_LINE_W-1:0] rand_line();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  //////////////////////////////
  // checks and handshakes
  //////////////////////////////

  task automatic check_value(input string name, input logic [`DC_LINE_W:0] got,
                             input logic [`DC_LINE_W:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout: %s handshake did not complete in 200 cycles, at %0t ns", what, $time);
    $display("Test failures found");
    $fatal(1, "stopped on timeout");
  endtask

  // called on a falling edge, returns on the falling edge after the accept
  task automatic send_req(input logic wr, input logic [`DC_ADDR_W-1:0] addr,
                          input logic [`DC_LINE_W-1:0] data);
    int waited;
    waited = 0;
    req_valid = 1'b1;
    req.write = wr;
    req.addr  = addr;
    req.wdata = data;
    while (!req_ready) begin
      @(negedge clk);
      waited++;
      if (waited >= 200) fail_timeout("request");
    end
    @(negedge clk);
    accepted_at = cycle_cnt;
    req_valid   = 1'b0;
    req.wdata   = rand_line();
  endtask

  // hold > 0 keeps rsp_ready low that many cycles after rsp_valid rises
  task automatic recv_rsp(input int hold, output dcache_pkg::cpu_rsp_t got);
    int waited;
    dcache_pkg::cpu_rsp_t held;
    waited = 0;
    rsp_ready = (hold == 0);
    while (!rsp_valid) begin
      @(negedge clk);
      waited++;
      if (waited >= 200) fail_timeout("response");
    end
    seen_at = cycle_cnt;
    held = rsp;
    repeat (hold) begin
      @(negedge clk);
      check_value("rsp_valid", rsp_valid, 1'b1);
      check_value("rsp", rsp, held);
      check_value("req_ready", req_ready, 1'b0);
    end
    rsp_ready = 1'b1;
    @(negedge clk);
    rsp_ready = 1'b0;
    // exactly one transfer
    check_value("rsp_valid", rsp_valid, 1'b0);
    check_value("req_ready", req_ready, 1'b1);
    got = held;
  endtask

  task automatic access(input logic wr, input logic [`DC_ADDR_W-1:0] addr,
                        input logic [`DC_LINE_W-1:0] data, input int hold);
    dcache_pkg::cpu_rsp_t got;
    logic [LINE_AW-1:0] line;
    line = addr[`DC_ADDR_W-1:`DC_OFFSET_W];
    send_req(wr, addr, data);
    if (wr) model_mem[int'(line)] = data;
    recv_rsp(hold, got);
    last_rsp = got;
    check_value("rsp.write", got.write, wr);
    check_value("rsp.rdata", got.rdata, model_read(line));
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    logic [`DC_ADDR_W-1:0] addr_a;
    logic [`DC_ADDR_W-1:0] addr_b;
    logic [`DC_LINE_W-1:0] data;
    int r;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // reset state, then a cold read
    check_value("req_ready", req_ready, 1'b1);
    check_value("rsp_valid", rsp_valid, 1'b0);
    addr_a = $random(seed);
    addr_a[15:14] = 2'b00;
    access(1'b0, addr_a, rand_line(), 0);

    // write then read back, the read hits
    addr_a = $random(seed);
    addr_a[15:14] = 2'b00;
    access(1'b1, addr_a, rand_line(), 0);
    addr_a[3:0] = ~addr_a[3:0];
    access(1'b0, addr_a, rand_line(), 0);
    check_value("hit latency", seen_at - accepted_at, 2);

    // conflict on one index, tags kept above the ones used so far
    addr_a = $random(seed);
    addr_a[15:14] = 2'b10;
    addr_b = addr_a ^ 16'h0400;
    data   = rand_line();
    access(1'b1, addr_a, data, 0);
    access(1'b0, addr_b, rand_line(), 0);
    check_value("rsp.rdata of B", last_rsp.rdata, line_pattern(addr_b[15:4]));
    access(1'b0, addr_a, rand_line(), 0);
    check_value("rsp.rdata of A", last_rsp.rdata, data);

    // back-pressure of 1 to 10 cycles
    addr_a = $random(seed);
    access(1'b0, addr_a, rand_line(), 1 + $unsigned($random(seed)) % 10);

    // mixed traffic, tags 0..3 over indices 0..7
    for (int i = 0; i < 400; i++) begin
      r = $random(seed);
      addr_a = $random(seed);
      addr_a[15:12] = 4'b0000;
      addr_a[9:7]   = 3'b000;
      repeat ($unsigned($random(seed)) % 4) @(negedge clk);
      access(r[0], addr_a, rand_line(), $unsigned($random(seed)) % 4);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: data_cache.f
+incdir+include
design/dcache_pkg.sv
design/tag_store.sv
design/line_store.sv
design/backing_mem.sv
design/dcache_ctrl.sv
design/data_cache.sv
testbench/data_cache_tb.sv

// File: Bender.yml
package:
  name: data_cache

sources:
  - include_dirs:
      - include
    files:
      - design/dcache_pkg.sv
      - design/tag_store.sv
      - design/line_store.sv
      - design/backing_mem.sv
      - design/dcache_ctrl.sv
      - design/data_cache.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/data_cache_tb.sv
